// ==== hdl/lq_settings.svh ====
// Load queue build settings
// Queue depth, data width and ROB tag width
`ifndef LQ_SETTINGS_SVH
`define LQ_SETTINGS_SVH

// Number of queue entries
// Must stay a power of two so indices wrap for free
`define LQ_DEPTH 8

// Data and address width of the memory port
`define LQ_XLEN 32

// Reorder buffer tag width
`define LQ_TAG_W 5

`endif

// ==== hdl/lq_pkg.sv ====
// Load queue shared types
// Access size, entry index, pointer, count, ROB tag and data word
`include "lq_settings.svh"

package lq_pkg;

  // Entry count and index width
  localparam int unsigned LQ_ENTRIES = `LQ_DEPTH;
  localparam int unsigned LQ_IDX_W = $clog2(`LQ_DEPTH);

  // Access size of a load, same encoding as funct3[1:0]
  typedef enum logic [1:0] {
    MEM_SIZE_BYTE = 2'b00,
    MEM_SIZE_HALF = 2'b01,
    MEM_SIZE_WORD = 2'b10
  } mem_size_e;

  // Entry index into the circular buffer
  typedef logic [LQ_IDX_W-1:0] lq_idx_t;

  // Head or tail pointer
  // Top bit is the wrap flag that tells full from empty
  typedef logic [LQ_IDX_W:0] lq_ptr_t;

  // Number of valid entries, zero up to a full queue
  typedef logic [$clog2(`LQ_DEPTH+1)-1:0] lq_count_t;

  // Reorder buffer tag
  typedef logic [`LQ_TAG_W-1:0] rob_tag_t;

  // Data or address word
  typedef logic [`LQ_XLEN-1:0] word_t;

endpackage

// ==== hdl/lq_age_scan.sv ====
// Oldest-first priority scan
// Walks the ready mask in circular order starting at the queue head
`timescale 1ns/1ps

module lq_age_scan (
  input  logic [lq_pkg::LQ_ENTRIES-1:0] i_ready,
  input  lq_pkg::lq_idx_t               i_head_idx,
  output logic                          o_found,
  output lq_pkg::lq_idx_t               o_idx
);

  import lq_pkg::*;

  // Entry index for each age position, position 0 is the head
  lq_idx_t scan_idx [LQ_ENTRIES];

  for (genvar g = 0; g < LQ_ENTRIES; g++) begin : g_order
    // Index wraps within the power-of-two depth
    assign scan_idx[g] = i_head_idx + lq_idx_t'(g);
  end

  // First ready position wins, that is the oldest entry
  always_comb begin
    o_found = 1'b0;
    o_idx   = i_head_idx;
    for (int i = 0; i < LQ_ENTRIES; i++) begin
      if (!o_found && i_ready[scan_idx[i]]) begin
        o_found = 1'b1;
        o_idx   = scan_idx[i];
      end
    end
  end

endmodule

// ==== hdl/lq_load_align.sv ====
// Load data alignment
// Byte and halfword extraction with sign or zero extension
`timescale 1ns/1ps
`include "lq_settings.svh"

module lq_load_align (
  input  lq_pkg::mem_size_e i_size,
  input  logic              i_sign_ext,
  input  logic [1:0]        i_addr_low,
  input  lq_pkg::word_t     i_word,
  output lq_pkg::word_t     o_data
);

  import lq_pkg::*;

  word_t       shifted;
  logic [7:0]  byte_val;
  logic [15:0] half_val;
  logic        byte_msb;
  logic        half_msb;

  // Move the addressed byte lane down to bit 0
  assign shifted  = i_word >> {i_addr_low, 3'b000};
  assign byte_val = shifted[7:0];
  // Halfword loads are aligned, so the shift also lands the right half
  assign half_val = shifted[15:0];

  // Fill bit is the top data bit for signed loads, zero otherwise
  assign byte_msb = i_sign_ext & byte_val[7];
  assign half_msb = i_sign_ext & half_val[15];

  always_comb begin
    case (i_size)
      MEM_SIZE_BYTE: begin
        o_data = {{(`LQ_XLEN-8){byte_msb}}, byte_val};
      end
      MEM_SIZE_HALF: begin
        o_data = {{(`LQ_XLEN-16){half_msb}}, half_val};
      end
      // Word passes through as read
      default: begin
        o_data = i_word;
      end
    endcase
  end

endmodule

// ==== hdl/lq_mem_port.sv ====
// Load queue memory port
// Single outstanding read, response routing and drain of flushed responses
`timescale 1ns/1ps

module lq_mem_port (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // Oldest entry waiting for memory
  input  logic                          i_cand_found,
  input  lq_pkg::lq_idx_t               i_cand_idx,
  input  lq_pkg::word_t                 i_cand_addr,
  input  lq_pkg::mem_size_e             i_cand_size,
  // Entry state for response routing
  input  logic [lq_pkg::LQ_ENTRIES-1:0] i_entry_valid,
  input  lq_pkg::mem_size_e             i_size [lq_pkg::LQ_ENTRIES],
  input  logic [lq_pkg::LQ_ENTRIES-1:0] i_sign_ext,
  input  logic                          i_flush_any,
  // Data memory
  input  lq_pkg::word_t                 i_mem_read_data,
  input  logic                          i_mem_read_valid,
  output logic                          o_mem_read_en,
  output lq_pkg::word_t                 o_mem_read_addr,
  output lq_pkg::mem_size_e             o_mem_read_size,
  // Completion back to the entry store
  output logic                          o_done_en,
  output lq_pkg::lq_idx_t               o_done_idx,
  output lq_pkg::word_t                 o_done_data
);

  import lq_pkg::*;

  logic       outstanding;
  // Set once the in-flight entry has been invalidated by a flush
  logic       stale;
  lq_idx_t    pend_idx;
  logic [1:0] pend_addr_low;

  // ====================================================================
  // Issue
  // ====================================================================
  // No issue while a read is out or while the queue is being flushed
  assign o_mem_read_en   = i_cand_found && !outstanding && !i_flush_any;
  assign o_mem_read_addr = i_cand_addr;
  assign o_mem_read_size = i_cand_size;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outstanding <= 1'b0;
      stale       <= 1'b0;
      pend_idx    <= '0;
    end else if (o_mem_read_en) begin
      outstanding <= 1'b1;
      stale       <= 1'b0;
      pend_idx    <= i_cand_idx;
    end else if (i_mem_read_valid && outstanding) begin
      // Response ends the read, live or drained
      outstanding <= 1'b0;
      stale       <= 1'b0;
    end else if (outstanding && !i_entry_valid[pend_idx]) begin
      // Slot may be reallocated before the response, remember the flush
      stale <= 1'b1;
    end
  end

  // Byte offset of the read in flight
  always_ff @(posedge i_clk) begin
    if (o_mem_read_en) begin
      pend_addr_low <= i_cand_addr[1:0];
    end
  end

  // ====================================================================
  // Response
  // ====================================================================
  lq_load_align u_align (
    .i_size     (i_size[pend_idx]),
    .i_sign_ext (i_sign_ext[pend_idx]),
    .i_addr_low (pend_addr_low),
    .i_word     (i_mem_read_data),
    .o_data     (o_done_data)
  );

  // Only a response for a still-live entry completes it
  assign o_done_en  = i_mem_read_valid && outstanding && !stale && i_entry_valid[pend_idx];
  assign o_done_idx = pend_idx;

endmodule

// ==== hdl/lq_entry_store.sv ====
// Load queue entry store
// Circular buffer with allocation, address CAM, age flush, head advance and tail retraction
`timescale 1ns/1ps

module lq_entry_store (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // Allocation at dispatch
  input  logic                          i_alloc_valid,
  input  lq_pkg::rob_tag_t              i_alloc_tag,
  input  lq_pkg::mem_size_e             i_alloc_size,
  input  logic                          i_alloc_sign_ext,
  // Address update by tag search
  input  logic                          i_addr_valid,
  input  lq_pkg::rob_tag_t              i_addr_tag,
  input  lq_pkg::word_t                 i_addr,
  // Flush
  input  lq_pkg::rob_tag_t              i_rob_head_tag,
  input  logic                          i_flush_en,
  input  lq_pkg::rob_tag_t              i_flush_tag,
  input  logic                          i_flush_all,
  // Memory port events
  input  logic                          i_issue_en,
  input  lq_pkg::lq_idx_t               i_issue_idx,
  input  logic                          i_done_en,
  input  lq_pkg::lq_idx_t               i_done_idx,
  input  lq_pkg::word_t                 i_done_data,
  // Result broadcast frees an entry
  input  logic                          i_free_en,
  input  lq_pkg::lq_idx_t               i_free_idx,
  // Per-entry state
  output logic [lq_pkg::LQ_ENTRIES-1:0] o_valid,
  output logic [lq_pkg::LQ_ENTRIES-1:0] o_addr_valid,
  output logic [lq_pkg::LQ_ENTRIES-1:0] o_issued,
  output logic [lq_pkg::LQ_ENTRIES-1:0] o_data_valid,
  output lq_pkg::rob_tag_t              o_tag [lq_pkg::LQ_ENTRIES],
  output lq_pkg::word_t                 o_addr [lq_pkg::LQ_ENTRIES],
  output lq_pkg::mem_size_e             o_size [lq_pkg::LQ_ENTRIES],
  output logic [lq_pkg::LQ_ENTRIES-1:0] o_sign_ext,
  output lq_pkg::word_t                 o_data [lq_pkg::LQ_ENTRIES],
  // Queue status
  output lq_pkg::lq_idx_t               o_head_idx,
  output logic                          o_full,
  output logic                          o_empty,
  output lq_pkg::lq_count_t             o_count
);

  import lq_pkg::*;

  typedef logic [LQ_ENTRIES-1:0] mask_t;

  // True when tag is younger than flush_tag, both seen from the ROB head
  // Modular subtraction gives the age within the tag space
  function automatic logic is_younger(input rob_tag_t tag, input rob_tag_t flush_tag,
                                      input rob_tag_t head_tag);
    rob_tag_t tag_age;
    rob_tag_t flush_age;
    tag_age   = tag - head_tag;
    flush_age = flush_tag - head_tag;
    return tag_age > flush_age;
  endfunction

  // ====================================================================
  // State
  // ====================================================================
  lq_ptr_t   head_ptr;
  lq_ptr_t   tail_ptr;
  mask_t     valid_q;
  mask_t     addr_valid_q;
  mask_t     issued_q;
  mask_t     data_valid_q;

  // Payload, written on events only
  rob_tag_t  tag_q [LQ_ENTRIES];
  word_t     addr_q [LQ_ENTRIES];
  mem_size_e size_q [LQ_ENTRIES];
  mask_t     sign_ext_q;
  word_t     data_q [LQ_ENTRIES];

  lq_idx_t   tail_idx;
  logic      full;
  logic      alloc_ok;
  lq_count_t count;
  mask_t     cam_hit;
  mask_t     flushed;
  mask_t     keep;
  mask_t     free_mask;
  lq_ptr_t   tail_target;
  lq_ptr_t   head_target;

  assign tail_idx = tail_ptr[LQ_IDX_W-1:0];
  // Same index with opposite wrap flag means every slot is taken
  assign full     = (head_ptr[LQ_IDX_W-1:0] == tail_idx) &&
                    (head_ptr[LQ_IDX_W] != tail_ptr[LQ_IDX_W]);
  assign alloc_ok = i_alloc_valid && !full;

  // Count valid bits, partial flush leaves holes in the pointer range
  always_comb begin
    count = '0;
    for (int i = 0; i < LQ_ENTRIES; i++) begin
      count = count + lq_count_t'(valid_q[i]);
    end
  end

  // Address CAM, first match on a waiting entry
  // Flush classification per entry
  always_comb begin
    for (int i = 0; i < LQ_ENTRIES; i++) begin
      cam_hit[i] = i_addr_valid && valid_q[i] && !addr_valid_q[i] &&
                   (tag_q[i] == i_addr_tag);
      flushed[i] = i_flush_en && valid_q[i] &&
                   is_younger(tag_q[i], i_flush_tag, i_rob_head_tag);
    end
  end

  assign keep      = valid_q & ~flushed;
  assign free_mask = i_free_en ? (mask_t'(1) << i_free_idx) : '0;

  // ====================================================================
  // Pointer scans
  // ====================================================================
  // Tail walks back over entries that are gone after this flush
  always_comb begin
    tail_target = tail_ptr;
    for (int s = 0; s < LQ_ENTRIES; s++) begin
      if (tail_target != head_ptr && !keep[tail_target[LQ_IDX_W-1:0] - lq_idx_t'(1)]) begin
        tail_target = tail_target - lq_ptr_t'(1);
      end
    end
  end

  // Head walks forward over invalid entries, the one freed now included
  always_comb begin
    head_target = head_ptr;
    for (int s = 0; s < LQ_ENTRIES; s++) begin
      if (head_target != tail_ptr &&
          !(valid_q[head_target[LQ_IDX_W-1:0]] && !free_mask[head_target[LQ_IDX_W-1:0]])) begin
        head_target = head_target + lq_ptr_t'(1);
      end
    end
  end

  // ====================================================================
  // Control update
  // ====================================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      head_ptr     <= '0;
      tail_ptr     <= '0;
      valid_q      <= '0;
      addr_valid_q <= '0;
      issued_q     <= '0;
      data_valid_q <= '0;
    end else if (i_flush_all) begin
      head_ptr     <= '0;
      tail_ptr     <= '0;
      valid_q      <= '0;
      addr_valid_q <= '0;
      issued_q     <= '0;
      data_valid_q <= '0;
    end else begin
      // Whole-vector updates first, single bits below override them
      if (i_flush_en) begin
        valid_q  <= keep;
        tail_ptr <= tail_target;
      end
      addr_valid_q <= addr_valid_q | cam_hit;
      if (i_issue_en) begin
        issued_q[i_issue_idx] <= 1'b1;
      end
      if (i_done_en) begin
        data_valid_q[i_done_idx] <= 1'b1;
      end
      if (i_free_en) begin
        valid_q[i_free_idx] <= 1'b0;
      end
      // New entry at the tail starts with no address and no data
      if (alloc_ok) begin
        valid_q[tail_idx]      <= 1'b1;
        addr_valid_q[tail_idx] <= 1'b0;
        issued_q[tail_idx]     <= 1'b0;
        data_valid_q[tail_idx] <= 1'b0;
        tail_ptr               <= tail_ptr + lq_ptr_t'(1);
      end
      head_ptr <= head_target;
    end
  end

  // Payload update
  always_ff @(posedge i_clk) begin
    if (alloc_ok) begin
      tag_q[tail_idx]      <= i_alloc_tag;
      size_q[tail_idx]     <= i_alloc_size;
      sign_ext_q[tail_idx] <= i_alloc_sign_ext;
    end
    for (int i = 0; i < LQ_ENTRIES; i++) begin
      if (cam_hit[i]) begin
        addr_q[i] <= i_addr;
      end
    end
    if (i_done_en) begin
      data_q[i_done_idx] <= i_done_data;
    end
  end

  assign o_valid      = valid_q;
  assign o_addr_valid = addr_valid_q;
  assign o_issued     = issued_q;
  assign o_data_valid = data_valid_q;
  assign o_tag        = tag_q;
  assign o_addr       = addr_q;
  assign o_size       = size_q;
  assign o_sign_ext   = sign_ext_q;
  assign o_data       = data_q;
  assign o_head_idx   = head_ptr[LQ_IDX_W-1:0];
  assign o_full       = full;
  assign o_empty      = (head_ptr == tail_ptr);
  assign o_count      = count;

endmodule

// ==== hdl/load_queue.sv ====
// Load queue top level
// Entry store, broadcast and memory scans, memory port and result bus
`timescale 1ns/1ps

module load_queue (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // Allocation at dispatch
  input  logic              i_alloc_valid,
  input  lq_pkg::rob_tag_t  i_alloc_tag,
  input  lq_pkg::mem_size_e i_alloc_size,
  input  logic              i_alloc_sign_ext,
  // Address update
  input  logic              i_addr_valid,
  input  lq_pkg::rob_tag_t  i_addr_tag,
  input  lq_pkg::word_t     i_addr,
  // Data memory response
  input  lq_pkg::word_t     i_mem_read_data,
  input  logic              i_mem_read_valid,
  // Result bus back-pressure
  input  logic              i_result_pending,
  // ROB head and flush
  input  lq_pkg::rob_tag_t  i_rob_head_tag,
  input  logic              i_flush_en,
  input  lq_pkg::rob_tag_t  i_flush_tag,
  input  logic              i_flush_all,
  // Status
  output logic              o_full,
  output logic              o_empty,
  output lq_pkg::lq_count_t o_count,
  // Data memory read
  output logic              o_mem_read_en,
  output lq_pkg::word_t     o_mem_read_addr,
  output lq_pkg::mem_size_e o_mem_read_size,
  // Result bus
  output logic              o_result_valid,
  output lq_pkg::rob_tag_t  o_result_tag,
  output lq_pkg::word_t     o_result_value
);

  import lq_pkg::*;

  // Entry state from the store
  logic [LQ_ENTRIES-1:0] ent_valid;
  logic [LQ_ENTRIES-1:0] ent_addr_valid;
  logic [LQ_ENTRIES-1:0] ent_issued;
  logic [LQ_ENTRIES-1:0] ent_data_valid;
  logic [LQ_ENTRIES-1:0] ent_sign_ext;
  rob_tag_t              ent_tag [LQ_ENTRIES];
  word_t                 ent_addr [LQ_ENTRIES];
  mem_size_e             ent_size [LQ_ENTRIES];
  word_t                 ent_data [LQ_ENTRIES];
  lq_idx_t               head_idx;

  // Scan inputs and results
  logic [LQ_ENTRIES-1:0] cdb_ready;
  logic [LQ_ENTRIES-1:0] mem_ready;
  logic                  cdb_found;
  lq_idx_t               cdb_idx;
  logic                  mem_found;
  lq_idx_t               mem_idx;

  // Memory completion
  logic                  done_en;
  lq_idx_t               done_idx;
  word_t                 done_data;

  lq_entry_store u_store (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_alloc_valid    (i_alloc_valid),
    .i_alloc_tag      (i_alloc_tag),
    .i_alloc_size     (i_alloc_size),
    .i_alloc_sign_ext (i_alloc_sign_ext),
    .i_addr_valid     (i_addr_valid),
    .i_addr_tag       (i_addr_tag),
    .i_addr           (i_addr),
    .i_rob_head_tag   (i_rob_head_tag),
    .i_flush_en       (i_flush_en),
    .i_flush_tag      (i_flush_tag),
    .i_flush_all      (i_flush_all),
    .i_issue_en       (o_mem_read_en),
    .i_issue_idx      (mem_idx),
    .i_done_en        (done_en),
    .i_done_idx       (done_idx),
    .i_done_data      (done_data),
    .i_free_en        (o_result_valid),
    .i_free_idx       (cdb_idx),
    .o_valid          (ent_valid),
    .o_addr_valid     (ent_addr_valid),
    .o_issued         (ent_issued),
    .o_data_valid     (ent_data_valid),
    .o_tag            (ent_tag),
    .o_addr           (ent_addr),
    .o_size           (ent_size),
    .o_sign_ext       (ent_sign_ext),
    .o_data           (ent_data),
    .o_head_idx       (head_idx),
    .o_full           (o_full),
    .o_empty          (o_empty),
    .o_count          (o_count)
  );

  // ====================================================================
  // Candidate selection
  // ====================================================================
  // Broadcast needs data, memory needs an address and no read yet
  assign cdb_ready = ent_valid & ent_data_valid;
  assign mem_ready = ent_valid & ent_addr_valid & ~ent_issued & ~ent_data_valid;

  lq_age_scan u_cdb_scan (
    .i_ready    (cdb_ready),
    .i_head_idx (head_idx),
    .o_found    (cdb_found),
    .o_idx      (cdb_idx)
  );

  lq_age_scan u_mem_scan (
    .i_ready    (mem_ready),
    .i_head_idx (head_idx),
    .o_found    (mem_found),
    .o_idx      (mem_idx)
  );

  lq_mem_port u_mem_port (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_cand_found     (mem_found),
    .i_cand_idx       (mem_idx),
    .i_cand_addr      (ent_addr[mem_idx]),
    .i_cand_size      (ent_size[mem_idx]),
    .i_entry_valid    (ent_valid),
    .i_size           (ent_size),
    .i_sign_ext       (ent_sign_ext),
    .i_flush_any      (i_flush_en | i_flush_all),
    .i_mem_read_data  (i_mem_read_data),
    .i_mem_read_valid (i_mem_read_valid),
    .o_mem_read_en    (o_mem_read_en),
    .o_mem_read_addr  (o_mem_read_addr),
    .o_mem_read_size  (o_mem_read_size),
    .o_done_en        (done_en),
    .o_done_idx       (done_idx),
    .o_done_data      (done_data)
  );

  // Result bus, held while the consumer is busy
  // A presented result frees its entry at the same edge
  assign o_result_valid = cdb_found && !i_result_pending;
  assign o_result_tag   = ent_tag[cdb_idx];
  assign o_result_value = ent_data[cdb_idx];

endmodule

// ==== testbench/lq_asserts.sv ====
// Concurrent checks on the load queue ports
// Result back-pressure, full and empty exclusion, single outstanding read
`timescale 1ns/1ps

module lq_asserts (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_result_pending,
  input  logic i_mem_read_valid,
  input  logic o_result_valid,
  input  logic o_full,
  input  logic o_empty,
  input  logic o_mem_read_en
);

  // High from an accepted read until its response
  logic rd_open;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_open <= 1'b0;
    end else if (o_mem_read_en) begin
      rd_open <= 1'b1;
    end else if (i_mem_read_valid) begin
      rd_open <= 1'b0;
    end
  end

  // No result while the consumer is busy
  a_no_result_when_pending: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_result_valid && i_result_pending))
    else $error("result presented while back-pressure is high");

  a_full_empty_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_full && o_empty))
    else $error("full and empty flags high together");

  // One read in memory at a time
  a_single_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    rd_open |-> !o_mem_read_en)
    else $error("second memory read issued before the response");

endmodule

bind load_queue lq_asserts u_asserts (.*);

// ==== testbench/tb_load_queue.sv ====
// Load queue testbench
// Stimulus table, memory model, LFSR, result monitor, flush tests and watchdog
`timescale 1ns/1ps

module tb_load_queue;

  import lq_pkg::*;

  localparam int NUM_ROWS = 10;
  localparam int ROW_BUDGET = 60;
  localparam int CLK_PERIOD = 8;

  typedef struct {
    rob_tag_t  tag;
    word_t     addr;
    mem_size_e size;
    logic      sext;
    word_t     mem_word;
    word_t     expected;
    string     name;
  } row_t;

  row_t      rows [NUM_ROWS];

  logic      i_clk;
  logic      i_rst_n;
  logic      i_alloc_valid;
  rob_tag_t  i_alloc_tag;
  mem_size_e i_alloc_size;
  logic      i_alloc_sign_ext;
  logic      i_addr_valid;
  rob_tag_t  i_addr_tag;
  word_t     i_addr;
  word_t     i_mem_read_data;
  logic      i_mem_read_valid;
  logic      i_result_pending;
  rob_tag_t  i_rob_head_tag;
  logic      i_flush_en;
  rob_tag_t  i_flush_tag;
  logic      i_flush_all;
  logic      o_full;
  logic      o_empty;
  lq_count_t o_count;
  logic      o_mem_read_en;
  word_t     o_mem_read_addr;
  mem_size_e o_mem_read_size;
  logic      o_result_valid;
  rob_tag_t  o_result_tag;
  word_t     o_result_value;

  logic [31:0] lfsr;
  logic        pending_random;
  logic        mem_busy;
  int          reads_seen;
  int          results_seen;
  int          pass_count;
  int          fail_count;
  int          err_count;

  load_queue DUT (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_alloc_valid(i_alloc_valid), .i_alloc_tag(i_alloc_tag),
    .i_alloc_size(i_alloc_size), .i_alloc_sign_ext(i_alloc_sign_ext),
    .i_addr_valid(i_addr_valid), .i_addr_tag(i_addr_tag), .i_addr(i_addr),
    .i_mem_read_data(i_mem_read_data), .i_mem_read_valid(i_mem_read_valid),
    .i_result_pending(i_result_pending), .i_rob_head_tag(i_rob_head_tag),
    .i_flush_en(i_flush_en), .i_flush_tag(i_flush_tag), .i_flush_all(i_flush_all),
    .o_full(o_full), .o_empty(o_empty), .o_count(o_count),
    .o_mem_read_en(o_mem_read_en), .o_mem_read_addr(o_mem_read_addr),
    .o_mem_read_size(o_mem_read_size), .o_result_valid(o_result_valid),
    .o_result_tag(o_result_tag), .o_result_value(o_result_value)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int take_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  task automatic set_row(input int i, input rob_tag_t tag, input word_t addr,
                         input mem_size_e size, input logic sext, input word_t mem_word,
                         input word_t expected, input string name);
    rows[i] = '{tag, addr, size, sext, mem_word, expected, name};
  endtask

  // Expected values worked out by hand from the byte lane and extension rules
  task automatic load_table();
    set_row(0, 5'd1,  32'h100, MEM_SIZE_BYTE, 1'b1, 32'h1234_5680, 32'hFFFF_FF80, "lb_neg_b0");
    set_row(1, 5'd2,  32'h105, MEM_SIZE_BYTE, 1'b0, 32'hA1B2_C3D4, 32'h0000_00C3, "lbu_b1");
    set_row(2, 5'd3,  32'h10A, MEM_SIZE_BYTE, 1'b1, 32'h7F6E_5D4C, 32'h0000_006E, "lb_pos_b2");
    set_row(3, 5'd4,  32'h10F, MEM_SIZE_BYTE, 1'b1, 32'h8877_6655, 32'hFFFF_FF88, "lb_neg_b3");
    set_row(4, 5'd5,  32'h110, MEM_SIZE_HALF, 1'b1, 32'h0000_9ABC, 32'hFFFF_9ABC, "lh_neg_lo");
    set_row(5, 5'd6,  32'h116, MEM_SIZE_HALF, 1'b0, 32'hFEDC_0000, 32'h0000_FEDC, "lhu_hi");
    set_row(6, 5'd7,  32'h118, MEM_SIZE_HALF, 1'b1, 32'h1357_2468, 32'h0000_2468, "lh_pos_lo");
    set_row(7, 5'd8,  32'h11C, MEM_SIZE_WORD, 1'b0, 32'hDEAD_BEEF, 32'hDEAD_BEEF, "lw");
    set_row(8, 5'd9,  32'h120, MEM_SIZE_WORD, 1'b1, 32'h8000_0001, 32'h8000_0001, "lw_sext");
    set_row(9, 5'd10, 32'h126, MEM_SIZE_HALF, 1'b1, 32'h8001_7FFF, 32'hFFFF_8001, "lh_neg_hi");
  endtask

  // Table word for a row address, otherwise a fill from the full address
  function automatic word_t mem_word(input word_t addr);
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].addr[31:2] == addr[31:2]) begin
        return rows[i].mem_word;
      end
    end
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic mismatch(input string name, input word_t expected, input word_t actual);
    $display("Error %s: expected %h, actual %h", name, expected, actual);
    err_count++;
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("PASS %s", name);
      pass_count++;
    end else begin
      $display("FAIL %s", name);
      fail_count++;
    end
  endtask

  // ======================================================================
  // Memory model, latency 1 to 4 cycles
  // ======================================================================
  initial begin
    word_t     a;
    word_t     exp_addr;
    mem_size_e exp_size;
    string     read_name;
    int        lat;
    forever begin
      @(posedge i_clk);
      if (i_rst_n && o_mem_read_en) begin
        a        = o_mem_read_addr;
        mem_busy = 1'b1;
        // Reads leave in allocation order, the last one is the flush test load
        if (reads_seen < NUM_ROWS) begin
          exp_addr  = rows[reads_seen].addr;
          exp_size  = rows[reads_seen].size;
          read_name = rows[reads_seen].name;
        end else begin
          exp_addr  = 32'h200;
          exp_size  = MEM_SIZE_WORD;
          read_name = "flush_read";
        end
        if (a !== exp_addr) begin
          mismatch({read_name, " read_addr"}, exp_addr, a);
        end
        if (o_mem_read_size !== exp_size) begin
          mismatch({read_name, " read_size"}, word_t'(exp_size), word_t'(o_mem_read_size));
        end
        reads_seen++;
        lat      = 1 + take_bits(2);
        repeat (lat - 1) @(posedge i_clk);
        @(negedge i_clk);
        i_mem_read_valid = 1'b1;
        i_mem_read_data  = mem_word(a);
        @(negedge i_clk);
        i_mem_read_valid = 1'b0;
        mem_busy         = 1'b0;
      end
    end
  end

  // Random back-pressure toggling
  always @(negedge i_clk) begin
    if (pending_random && take_bits(2) == 0) begin
      i_result_pending <= ~i_result_pending;
    end
  end

  // ======================================================================
  // Result monitor, rows expected in allocation order
  // ======================================================================
  always @(posedge i_clk) begin
    int errs;
    if (i_rst_n && o_result_valid) begin
      if (i_result_pending) begin
        $display("Result presented while back-pressure is high, tag %0d", o_result_tag);
        err_count++;
      end
      if (results_seen >= NUM_ROWS) begin
        $display("Unexpected result for tag %0d", o_result_tag);
        err_count++;
        fail_count++;
      end else begin
        errs = err_count;
        if (o_result_tag !== rows[results_seen].tag) begin
          mismatch({rows[results_seen].name, " tag"}, word_t'(rows[results_seen].tag),
                   word_t'(o_result_tag));
        end
        if (o_result_value !== rows[results_seen].expected) begin
          mismatch(rows[results_seen].name, rows[results_seen].expected, o_result_value);
        end
        close_test(rows[results_seen].name, errs);
        results_seen++;
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    #((NUM_ROWS + 6) * ROW_BUDGET * CLK_PERIOD);
    $display("Timeout: the run did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    int errs;
    lfsr = 32'h8885;
    i_clk = 1'b0;
    i_rst_n = 1'b0;
    i_alloc_valid = 1'b0;
    i_alloc_tag = '0;
    i_alloc_size = MEM_SIZE_WORD;
    i_alloc_sign_ext = 1'b0;
    i_addr_valid = 1'b0;
    i_addr_tag = '0;
    i_addr = '0;
    i_mem_read_data = '0;
    i_mem_read_valid = 1'b0;
    i_result_pending = 1'b0;
    i_rob_head_tag = '0;
    i_flush_en = 1'b0;
    i_flush_tag = '0;
    i_flush_all = 1'b0;
    pending_random = 1'b0;
    mem_busy = 1'b0;
    reads_seen = 0;
    results_seen = 0;
    pass_count = 0;
    fail_count = 0;
    err_count = 0;
    load_table();

    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    // Idle state after reset
    @(negedge i_clk);
    errs = err_count;
    if (o_empty !== 1'b1) mismatch("reset_empty", 1, o_empty);
    if (o_count !== 0) mismatch("reset_count", 0, o_count);
    if (o_mem_read_en !== 1'b0) mismatch("reset_read_en", 0, o_mem_read_en);
    if (o_result_valid !== 1'b0) mismatch("reset_result_valid", 0, o_result_valid);
    close_test("reset_state", errs);

    // Table rows, allocate then supply the address, waiting while full
    pending_random = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      while (o_full) @(negedge i_clk);
      i_alloc_valid    = 1'b1;
      i_alloc_tag      = rows[i].tag;
      i_alloc_size     = rows[i].size;
      i_alloc_sign_ext = rows[i].sext;
      @(negedge i_clk);
      i_alloc_valid = 1'b0;
      i_addr_valid  = 1'b1;
      i_addr_tag    = rows[i].tag;
      i_addr        = rows[i].addr;
      @(negedge i_clk);
      i_addr_valid = 1'b0;
    end
    wait (results_seen == NUM_ROWS);
    @(negedge i_clk);
    pending_random   = 1'b0;
    i_result_pending = 1'b0;
    while (!o_empty || mem_busy) @(negedge i_clk);

    // Eight loads with no address fill the queue, a ninth is dropped
    errs = err_count;
    for (int k = 0; k < 9; k++) begin
      i_alloc_valid    = 1'b1;
      i_alloc_tag      = rob_tag_t'(16 + k);
      i_alloc_size     = MEM_SIZE_WORD;
      i_alloc_sign_ext = 1'b0;
      @(negedge i_clk);
      i_alloc_valid = 1'b0;
      if (k == 7) begin
        if (o_full !== 1'b1) mismatch("full_flag", 1, o_full);
        if (o_count !== 8) mismatch("full_count", 8, o_count);
      end
    end
    if (o_full !== 1'b1) mismatch("ninth_full_flag", 1, o_full);
    if (o_count !== 8) mismatch("ninth_count", 8, o_count);
    close_test("fill_queue", errs);

    // Partial flush at tag 17 with a read in flight for tag 18
    errs = err_count;
    i_rob_head_tag = 5'd16;
    i_addr_valid   = 1'b1;
    i_addr_tag     = 5'd18;
    i_addr         = 32'h200;
    @(negedge i_clk);
    i_addr_valid = 1'b0;
    while (!mem_busy) @(negedge i_clk);
    i_flush_en  = 1'b1;
    i_flush_tag = 5'd17;
    @(negedge i_clk);
    i_flush_en = 1'b0;
    // Tags 18 to 23 are younger than 17, two entries remain
    if (o_count !== 2) mismatch("flush_count", 2, o_count);
    while (mem_busy) @(negedge i_clk);
    repeat (4) @(negedge i_clk);
    if (o_count !== 2) mismatch("flush_count_after_drain", 2, o_count);
    if (o_empty !== 1'b0) mismatch("flush_not_empty", 0, o_empty);
    i_flush_all = 1'b1;
    @(negedge i_clk);
    i_flush_all = 1'b0;
    if (o_empty !== 1'b1) mismatch("flush_all_empty", 1, o_empty);
    if (o_count !== 0) mismatch("flush_all_count", 0, o_count);
    repeat (4) @(negedge i_clk);
    close_test("partial_and_full_flush", errs);

    $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/lq_pkg.sv
hdl/lq_age_scan.sv
hdl/lq_load_align.sv
hdl/lq_mem_port.sv
hdl/lq_entry_store.sv
hdl/load_queue.sv
testbench/lq_asserts.sv
testbench/tb_load_queue.sv

// ==== Makefile ====
# Verilator build and run for the load queue testbench

VERILATOR ?= verilator
TOP       ?= tb_load_queue
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := hdl/lq_settings.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
